/* include/traffic_defines.svh */
// build-time constants for the mesh traffic generator
// mesh size, class mix, packet size range and random seeds
// included by the package, the rtl that needs them and the testbench

`ifndef TRAFFIC_DEFINES_SVH
`define TRAFFIC_DEFINES_SVH

// square mesh with one endpoint per router
// both transposes rely on equal width and height
// must be a power of two so coordinates wrap for free
`define MESH_N 4

// share of injected packets per class in percent
// the four values have to add up to 100
`define C0_PCT 40
`define C1_PCT 30
`define C2_PCT 30
`define C3_PCT 0

// packet length in flits, both ends inclusive
`define PCK_SIZE_MIN 2
`define PCK_SIZE_MAX 5

// lfsr start values
// any nonzero value works, keep them distinct so the
// three streams do not run in lockstep
`define DEST_SEED  16'hace1
`define CLASS_SEED 16'h5eed
`define SIZE_SEED  16'h3c96

`endif

/* design/traffic_pkg.sv */
// shared types of the mesh traffic generator
// imported by every rtl module and by the testbench

`include "traffic_defines.svh"

package traffic_pkg;

    // derived widths
    localparam int COORD_W = $clog2(`MESH_N);
    localparam int SIZE_W  = $clog2(`PCK_SIZE_MAX + 1);

    typedef logic [COORD_W-1:0] coord_t;    // one mesh coordinate
    typedef logic [1:0]         pck_class_t; // up to four classes
    typedef logic [SIZE_W-1:0]  pck_size_t;  // length in flits
    typedef logic [15:0]        rnd_word_t;  // one lfsr word

    // endpoint address, y in the upper bits
    typedef struct packed {
        coord_t y;
        coord_t x;
    } e_addr_t;

    // destination selection, chosen at runtime
    typedef enum logic [2:0] {
        PAT_RANDOM         = 3'd0,
        PAT_TRANSPOSE1     = 3'd1,
        PAT_TRANSPOSE2     = 3'd2,
        PAT_BIT_COMPLEMENT = 3'd3,
        PAT_TORNADO        = 3'd4
    } traffic_pattern_e;

    // one generated packet descriptor
    typedef struct packed {
        e_addr_t    dest;
        logic       valid_dst;  // dest differs from the source
        pck_class_t pck_class;
        pck_size_t  pck_size;
    } pck_info_t;

endpackage

/* design/traffic_lfsr.sv */
// 16-bit random source for the traffic generator
// maximal-length galois lfsr, loads SEED on reset and
// advances one state per clock with step high

`timescale 1ns/100ps

module traffic_lfsr
    import traffic_pkg::*;
#(
    parameter rnd_word_t SEED = 16'h0001  // must be nonzero
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      step,
    output rnd_word_t rnd
);

    // x^16 + x^14 + x^13 + x^11 + 1 in right-shift galois form
    localparam rnd_word_t TAPS = 16'hb400;

    rnd_word_t state;
    rnd_word_t state_next;

    // feedback bit leaves at the bottom and is folded into the taps
    always_comb begin
        state_next = state >> 1;
        if (state[0]) begin
            state_next = state_next ^ TAPS;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEED;
        end else if (step) begin
            state <= state_next;
        end
    end

    assign rnd = state;  // current word, valid until the next step

endmodule

/* design/dest_pattern_gen.sv */
// destination address for one request of a 2d mesh endpoint
// pure combinational, applies the selected traffic pattern to the
// source coordinates or takes random coordinates from rnd
// valid_dst drops when a pattern maps the source onto itself

`timescale 1ns/100ps

`include "traffic_defines.svh"

module dest_pattern_gen
    import traffic_pkg::*;
(
    input  traffic_pattern_e pattern,
    input  e_addr_t          src_addr,
    input  rnd_word_t        rnd,
    output e_addr_t          dest,
    output logic             valid_dst
);

    // highest coordinate on each side
    localparam coord_t COORD_MAX = coord_t'(`MESH_N - 1);

    // tornado moves every coordinate by N/2 - 1
    localparam coord_t TORNADO_OFS = coord_t'((`MESH_N / 2 - 1) % `MESH_N);

    // all sums below wrap modulo MESH_N through the coord_t width
    always_comb begin
        dest = src_addr;
        case (pattern)
            PAT_RANDOM: begin
                // low bits of the lfsr word, uniform over the mesh
                dest.x = rnd[COORD_W-1:0];
                dest.y = rnd[2*COORD_W-1:COORD_W];
            end
            PAT_TRANSPOSE1: begin
                // mirror across the anti-diagonal
                dest.x = COORD_MAX - src_addr.y;
                dest.y = COORD_MAX - src_addr.x;
            end
            PAT_TRANSPOSE2: begin
                dest.x = src_addr.y;  // mirror across the diagonal
                dest.y = src_addr.x;
            end
            PAT_BIT_COMPLEMENT: begin
                dest.x = ~src_addr.x;
                dest.y = ~src_addr.y;
            end
            PAT_TORNADO: begin
                dest.x = src_addr.x + TORNADO_OFS;
                dest.y = src_addr.y + TORNADO_OFS;
            end
            default: begin
                dest = src_addr;  // unknown code, flagged below as unusable
            end
        endcase
    end

    // every coordinate is in range since MESH_N is a power of two,
    // so only self traffic has to be filtered
    assign valid_dst = (dest != src_addr);

endmodule

/* design/pck_attr_gen.sv */
// packet class and packet size of one request
// class follows the fixed percentages of the defines header,
// size is spread over PCK_SIZE_MIN..PCK_SIZE_MAX
// both are combinational functions of their random words

`timescale 1ns/100ps

`include "traffic_defines.svh"

module pck_attr_gen
    import traffic_pkg::*;
(
    input  rnd_word_t  class_rnd,
    input  rnd_word_t  size_rnd,
    output pck_class_t pck_class,
    output pck_size_t  pck_size
);

    // cumulative class limits on the 0..99 scale
    localparam int unsigned C0_LIM = `C0_PCT;
    localparam int unsigned C1_LIM = C0_LIM + `C1_PCT;
    localparam int unsigned C2_LIM = C1_LIM + `C2_PCT;
    localparam int unsigned PCT_SUM = C2_LIM + `C3_PCT;

    localparam int unsigned SIZE_SPAN = `PCK_SIZE_MAX - `PCK_SIZE_MIN + 1;

    logic [6:0] class_r;     // 0..99
    rnd_word_t  size_ofs;    // 0..SIZE_SPAN-1

    // a class mix that does not add up would skew every class
    if (PCT_SUM != 100) begin : g_pct_check
        $error("class percentages add up to %0d instead of 100", PCT_SUM);
    end

    assign class_r = 7'(class_rnd % 16'd100);

    always_comb begin
        if (class_r < C0_LIM) begin
            pck_class = 2'd0;
        end else if (class_r < C1_LIM) begin
            pck_class = 2'd1;
        end else if (class_r < C2_LIM) begin
            pck_class = 2'd2;
        end else begin
            pck_class = 2'd3;  // only reached with C3_PCT above zero
        end
    end

    // offset into the size range, then shift up to the minimum
    assign size_ofs = rnd_word_t'(size_rnd % SIZE_SPAN);
    assign pck_size = pck_size_t'(size_ofs + `PCK_SIZE_MIN);

endmodule

/* design/traffic_gen.sv */
// synthetic traffic generator for one endpoint of a 4x4 mesh noc
// a one-cycle gen strobe returns one packet descriptor on the next
// clock with pck_strobe high for that cycle
// pattern and src_addr are sampled together with gen

`timescale 1ns/100ps

`include "traffic_defines.svh"

module traffic_gen
    import traffic_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             gen,
    input  traffic_pattern_e pattern,
    input  e_addr_t          src_addr,
    output logic             pck_strobe,
    output pck_info_t        pck_info
);

    rnd_word_t  dest_rnd;
    rnd_word_t  class_rnd;
    rnd_word_t  size_rnd;

    e_addr_t    next_dest;
    logic       next_valid_dst;
    pck_class_t next_class;
    pck_size_t  next_size;
    pck_info_t  next_info;

    // one random stream per field, all advance on every request
    traffic_lfsr #(
        .SEED (`DEST_SEED)
    ) dest_rnd_inst (
        .clk   (clk),
        .reset (reset),
        .step  (gen),
        .rnd   (dest_rnd)
    );

    traffic_lfsr #(
        .SEED (`CLASS_SEED)
    ) class_rnd_inst (
        .clk   (clk),
        .reset (reset),
        .step  (gen),
        .rnd   (class_rnd)
    );

    traffic_lfsr #(
        .SEED (`SIZE_SEED)
    ) size_rnd_inst (
        .clk   (clk),
        .reset (reset),
        .step  (gen),
        .rnd   (size_rnd)
    );

    dest_pattern_gen dest_gen_inst (
        .pattern   (pattern),
        .src_addr  (src_addr),
        .rnd       (dest_rnd),
        .dest      (next_dest),
        .valid_dst (next_valid_dst)
    );

    pck_attr_gen attr_gen_inst (
        .class_rnd (class_rnd),
        .size_rnd  (size_rnd),
        .pck_class (next_class),
        .pck_size  (next_size)
    );

    // descriptor built from the words current at the gen edge
    assign next_info = '{
        dest:      next_dest,
        valid_dst: next_valid_dst,
        pck_class: next_class,
        pck_size:  next_size
    };

    // one cycle latency, no back-pressure
    always_ff @(posedge clk) begin
        if (reset) begin
            pck_strobe <= 1'b0;
            pck_info   <= '0;
        end else begin
            pck_strobe <= gen;
            if (gen) begin
                pck_info <= next_info;  // held until the next request
            end
        end
    end

endmodule

/* testbench/traffic_gen_checker.sv */
// concurrent checks on the outputs of the mesh traffic generator
// bound into traffic_gen by the testbench, covers strobe timing,
// reset values and the legal class and size ranges

`timescale 1ns/100ps

`include "traffic_defines.svh"

module traffic_gen_checker
    import traffic_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      gen,
    input logic      pck_strobe,
    input pck_info_t pck_info
);

    int unsigned fail_count = 0;  // summed into the final verdict

    // output register is cleared while reset is applied
    reset_clear: assert property (@(posedge clk) reset |=> !pck_strobe && pck_info == '0)
        else begin
            $error("pck_strobe or pck_info not cleared by reset");
            fail_count++;
        end

    // exactly one cycle of latency
    strobe_after_gen: assert property (@(posedge clk) !reset && gen |=> pck_strobe)
        else begin
            $error("no pck_strobe in the cycle after gen");
            fail_count++;
        end

    strobe_only_after_gen: assert property (@(posedge clk) reset || !gen |=> !pck_strobe)
        else begin
            $error("pck_strobe high without a gen strobe one cycle before");
            fail_count++;
        end

    // descriptor holds between requests
    info_held: assert property (@(posedge clk) !reset && !gen |=> $stable(pck_info))
        else begin
            $error("pck_info changed without a request");
            fail_count++;
        end

    // class 3 has a zero share
    class_range: assert property (@(posedge clk)
        pck_strobe && (`C3_PCT == 0) |-> pck_info.pck_class != 2'd3)
        else begin
            $error("pck_class 3 produced although its share is zero");
            fail_count++;
        end

    size_range: assert property (@(posedge clk) pck_strobe |->
        pck_info.pck_size >= `PCK_SIZE_MIN && pck_info.pck_size <= `PCK_SIZE_MAX)
        else begin
            $error("pck_size outside the packet size range");
            fail_count++;
        end

endmodule

/* testbench/traffic_gen_tb.sv */
// testbench for the mesh traffic generator
// runs every traffic pattern with random sources and gaps, checks
// dest and valid_dst against a model of the pattern rules and
// tracks class and size coverage while the checker covers timing

`timescale 1ns/100ps

`include "traffic_defines.svh"

module traffic_gen_tb
    import traffic_pkg::*;
;

    localparam int NUM_PATTERNS   = 5;
    localparam int REQS_PER_PAT   = 40;
    localparam int TIMEOUT_CYCLES = NUM_PATTERNS * REQS_PER_PAT * 4 + 200;

    // one outstanding request as seen at the gen edge
    typedef struct packed {
        traffic_pattern_e pattern;
        e_addr_t          src;
    } req_t;

    logic             clk = 1'b0;
    logic             reset;
    logic             gen;
    traffic_pattern_e pattern;
    e_addr_t          src_addr;
    logic             pck_strobe;
    pck_info_t        pck_info;

    integer      seed = 76176;
    int unsigned errors = 0;
    int unsigned checker_fails;
    int unsigned cycle_count = 0;
    req_t        pending[$];
    logic [3:0]  class_seen = '0;
    logic        size_min_seen = 1'b0;
    logic        size_max_seen = 1'b0;

    traffic_gen traffic_gen_inst (
        .clk        (clk),
        .reset      (reset),
        .gen        (gen),
        .pattern    (pattern),
        .src_addr   (src_addr),
        .pck_strobe (pck_strobe),
        .pck_info   (pck_info)
    );

    bind traffic_gen traffic_gen_checker checker_inst (
        .clk        (clk),
        .reset      (reset),
        .gen        (gen),
        .pck_strobe (pck_strobe),
        .pck_info   (pck_info)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // pattern rules on plain integers modulo the mesh side
    function automatic e_addr_t model_dest(input traffic_pattern_e pat, input e_addr_t src);
        int n;
        int x;
        int y;
        int dx;
        int dy;
        n = `MESH_N;
        x = src.x;
        y = src.y;
        dx = x;
        dy = y;
        case (pat)
            PAT_TRANSPOSE1: begin
                dx = n - 1 - y;
                dy = n - 1 - x;
            end
            PAT_TRANSPOSE2: begin
                dx = y;
                dy = x;
            end
            PAT_BIT_COMPLEMENT: begin
                dx = n - 1 - x;  // bit inversion for a power of two side
                dy = n - 1 - y;
            end
            PAT_TORNADO: begin
                dx = (x + n / 2 - 1) % n;
                dy = (y + n / 2 - 1) % n;
            end
            default: ;
        endcase
        model_dest.x = coord_t'(dx);
        model_dest.y = coord_t'(dy);
    endfunction

    // lowest source that a pattern maps onto itself
    function automatic bit find_self_source(input traffic_pattern_e pat, output e_addr_t src);
        e_addr_t cand;
        find_self_source = 1'b0;
        src = '0;
        for (int i = `MESH_N * `MESH_N - 1; i >= 0; i--) begin
            cand = e_addr_t'(i);
            if (model_dest(pat, cand) == cand) begin
                src = cand;
                find_self_source = 1'b1;
            end
        end
    endfunction

    task automatic send_request(input traffic_pattern_e pat, input e_addr_t src);
        @(negedge clk);
        gen = 1'b1;
        pattern = pat;
        src_addr = src;
        pending.push_back('{pattern: pat, src: src});
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            gen = 1'b0;
        end
    endtask

    task automatic check_descriptor(input req_t req);
        e_addr_t exp_dest;
        logic    exp_valid;
        exp_dest = model_dest(req.pattern, req.src);
        if (req.pattern == PAT_RANDOM) begin
            exp_valid = (pck_info.dest != req.src);  // dest itself is random
        end else begin
            exp_valid = (exp_dest != req.src);
            assert (pck_info.dest == exp_dest) else begin
                $display("FAILED pck_info.dest: expected %h, got %h", exp_dest, pck_info.dest);
                errors++;
            end
        end
        assert (pck_info.valid_dst == exp_valid) else begin
            $display("FAILED pck_info.valid_dst: expected %h, got %h",
                     exp_valid, pck_info.valid_dst);
            errors++;
        end
        class_seen[pck_info.pck_class] = 1'b1;
        if (pck_info.pck_size == `PCK_SIZE_MIN) begin
            size_min_seen = 1'b1;
        end
        if (pck_info.pck_size == `PCK_SIZE_MAX) begin
            size_max_seen = 1'b1;
        end
    endtask

    // outputs sampled half a cycle after the rising edge
    always @(negedge clk) begin
        if (!reset && pck_strobe) begin
            if (pending.size() == 0) begin
                $display("descriptor came back with no request outstanding");
                errors++;
            end else begin
                check_descriptor(pending.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        e_addr_t          self_src;
        e_addr_t          src;
        traffic_pattern_e pat;
        int               gap;
        reset = 1'b1;
        gen = 1'b0;
        pattern = PAT_RANDOM;
        src_addr = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        idle_cycles(2);

        for (int p = 0; p < NUM_PATTERNS; p++) begin
            pat = traffic_pattern_e'(p);
            if (pat != PAT_RANDOM && find_self_source(pat, self_src)) begin
                send_request(pat, self_src);  // expects valid_dst low
                idle_cycles(1);
            end
            for (int r = 0; r < REQS_PER_PAT; r++) begin
                src = e_addr_t'($random(seed));
                send_request(pat, src);
                gap = $unsigned($random(seed)) % 3;  // zero gives a burst
                idle_cycles(gap);
            end
        end
        idle_cycles(4);

        assert (pending.size() == 0) else begin
            $display("%0d requests never got a descriptor", pending.size());
            errors++;
        end
        assert (class_seen[2:0] == 3'b111) else begin
            $display("not every class from 0 to 2 came up during the run");
            errors++;
        end
        assert (size_min_seen && size_max_seen) else begin
            $display("packet size never reached one end of its range");
            errors++;
        end

        checker_fails = traffic_gen_inst.checker_inst.fail_count;
        $display("errors: %0d testbench checks, %0d bound assertions", errors, checker_fails);
        if (errors == 0 && checker_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
design/traffic_pkg.sv
design/traffic_lfsr.sv
design/dest_pattern_gen.sv
design/pck_attr_gen.sv
design/traffic_gen.sv
testbench/traffic_gen_checker.sv
testbench/traffic_gen_tb.sv

/* Makefile */
# Verilator build and run of the mesh traffic generator testbench

TOP = traffic_gen_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
